/* hw/ebusPkg.sv */
`default_nettype none

package ebusPkg;

  // EBUS diagnostic field widths
  localparam int DIAG_SEL_W  = 4;   // ds[0:3], ds[0] lands on the MSB
  localparam int DIAG_FUNC_W = 3;   // ds[4:6]
  localparam int EBUS_DATA_W = 36;  // Full PDP-10 word

  typedef logic [DIAG_SEL_W-1:0]  diagSel_t;
  typedef logic [DIAG_FUNC_W-1:0] diagFunc_t;
  typedef logic [EBUS_DATA_W-1:0] ebusWord_t;

  // Device select that addresses the CLK slice
  localparam diagSel_t CLK_SEL = 4'd0;

  // Function codes that put a word back on the bus
  localparam diagFunc_t RD_FUNC_STATUS = 3'd4;
  localparam diagFunc_t RD_FUNC_COUNT  = 3'd5;

  // True for any code that only reads back
  function automatic logic isReadFunc(input diagFunc_t f);
    return (f == RD_FUNC_STATUS) || (f == RD_FUNC_COUNT);
  endfunction

endpackage

`default_nettype wire

/* hw/clkPkg.sv */
`default_nettype none

package clkPkg;

  // CLK diagnostic functions, as the front end issues them
  typedef enum logic [ebusPkg::DIAG_FUNC_W-1:0] {
    FUNC_STOP        = 3'd0,
    FUNC_START       = 3'd1,
    FUNC_SINGLE_STEP = 3'd2,
    FUNC_BURST       = 3'd3,
    FUNC_READ_STATUS = ebusPkg::RD_FUNC_STATUS,
    FUNC_READ_COUNT  = ebusPkg::RD_FUNC_COUNT,
    FUNC_CLR_RESET   = 3'd6,
    FUNC_SET_RESET   = 3'd7
  } clkFunc_t;

  // EBOX clock run state
  typedef enum logic [1:0] {
    IDLE,     // Clock stopped
    RUNNING,  // Free running
    BURST     // Counted cycles
  } runState_t;

  // Counter widths
  localparam int BURST_CNT_W = 8;   // Burst length from data bits 7:0
  localparam int CYCLE_CNT_W = 32;  // Widest EBOX cycle counter

  typedef logic [BURST_CNT_W-1:0] burstCnt_t;
  typedef logic [CYCLE_CNT_W-1:0] cycleCnt_t;

  // Status word layout
  localparam int STAT_MR_RESET_BIT = 0;
  localparam int STAT_RUNNING_BIT  = 1;
  localparam int STAT_STATE_LSB    = 2;  // Two bits of run state
  localparam int STAT_BURST_LSB    = 4;  // Eight bits of burst count

endpackage

`default_nettype wire

/* hw/diagDecode.sv */
`default_nettype none

module diagDecode (
  input  wire logic               masterClk,
  input  wire logic               rstN,
  input  wire ebusPkg::diagSel_t  diagSel,
  input  wire ebusPkg::diagFunc_t diagFunc,
  input  wire logic               diagStrobe,
  output logic                    funcPulse,
  output clkPkg::clkFunc_t        func
);

  // Bus sample stage
  logic               strobeQ;     // Strobe as sampled this edge
  logic               strobePrevQ; // One edge older
  ebusPkg::diagSel_t  selQ;
  ebusPkg::diagFunc_t funcQ;

  logic strobeRise;
  logic selMatch;

  // Every edge, no qualification
  always_ff @(posedge masterClk) begin
    if (!rstN) begin
      strobeQ     <= 1'b0;
      strobePrevQ <= 1'b0;
    end else begin
      strobeQ     <= diagStrobe;
      strobePrevQ <= strobeQ;
    end
  end

  // Select and function ride along with the strobe sample
  always_ff @(posedge masterClk) begin
    selQ  <= diagSel;
    funcQ <= diagFunc;
  end

  assign strobeRise = strobeQ && !strobePrevQ;     // Only the first cycle of a held strobe
  assign selMatch   = (selQ == ebusPkg::CLK_SEL);  // Other devices are ignored

  // One pulse per strobe rise aimed at CLK
  always_ff @(posedge masterClk) begin
    if (!rstN) begin
      funcPulse <= 1'b0;
      func      <= clkPkg::FUNC_STOP;
    end else begin
      funcPulse <= strobeRise && selMatch;
      if (strobeRise && selMatch) begin
        func <= clkPkg::clkFunc_t'(funcQ); // Held until the next command
      end
    end
  end

endmodule

`default_nettype wire

/* hw/clkExecute.sv */
`default_nettype none

module clkExecute (
  input  wire logic              masterClk,
  input  wire logic              rstN,
  input  wire logic              funcPulse,
  input  wire clkPkg::clkFunc_t  func,
  input  wire clkPkg::burstCnt_t burstLen,
  output logic                   mrReset,
  output logic                   running,
  output logic                   eboxClkEn,
  output clkPkg::runState_t      state,
  output clkPkg::burstCnt_t      burstCnt
);

  clkPkg::runState_t stateNext;
  clkPkg::burstCnt_t burstNext;
  logic              mrResetNext;
  logic              cmdValid;

  // Reads belong to clkStatus
  assign cmdValid = funcPulse && !ebusPkg::isReadFunc(func);

  always_comb begin
    stateNext   = state;
    burstNext   = burstCnt;
    mrResetNext = mrReset;

    // Burst countdown, one per enabled cycle
    if (state == clkPkg::BURST) begin
      if (burstCnt != '0) begin
        burstNext = burstCnt - clkPkg::burstCnt_t'(1);
      end
      if (burstCnt <= clkPkg::burstCnt_t'(1)) begin
        stateNext = clkPkg::IDLE;  // Last cycle goes out now
      end
    end

    // A new command overrides whatever is in flight
    if (cmdValid) begin
      case (func)
        clkPkg::FUNC_STOP: begin
          stateNext = clkPkg::IDLE;
          burstNext = '0;
        end
        clkPkg::FUNC_START: begin
          stateNext = clkPkg::RUNNING;
          burstNext = '0;  // Free run has no count
        end
        clkPkg::FUNC_SINGLE_STEP: begin
          stateNext = clkPkg::BURST;  // Burst of one
          burstNext = clkPkg::burstCnt_t'(1);
        end
        clkPkg::FUNC_BURST: begin
          burstNext = burstLen;
          if (burstLen == '0) begin
            stateNext = clkPkg::IDLE;  // Empty burst, nothing to run
          end else begin
            stateNext = clkPkg::BURST;
          end
        end
        clkPkg::FUNC_CLR_RESET: mrResetNext = 1'b0;
        clkPkg::FUNC_SET_RESET: mrResetNext = 1'b1;
        default: ;  // Read codes never get here
      endcase
    end
  end

  // Master reset comes up asserted
  always_ff @(posedge masterClk) begin
    if (!rstN) begin
      state    <= clkPkg::IDLE;
      burstCnt <= '0;
      mrReset  <= 1'b1;
    end else begin
      state    <= stateNext;
      burstCnt <= burstNext;
      mrReset  <= mrResetNext;
    end
  end

  // Clock gate straight from registered state
  always_comb begin
    case (state)
      clkPkg::RUNNING: eboxClkEn = 1'b1;
      clkPkg::BURST:   eboxClkEn = (burstCnt != '0);
      default:         eboxClkEn = 1'b0;
    endcase
  end

  assign running = (state != clkPkg::IDLE);  // Clock is on in either run state

endmodule

`default_nettype wire

/* hw/clkStatus.sv */
`default_nettype none

module clkStatus #(
  parameter int CYCLE_CNT_W = $bits(clkPkg::cycleCnt_t)
) (
  input  wire logic              masterClk,
  input  wire logic              rstN,
  input  wire logic              funcPulse,
  input  wire clkPkg::clkFunc_t  func,
  input  wire logic              eboxClkEn,
  input  wire logic              mrReset,
  input  wire logic              running,
  input  wire clkPkg::runState_t state,
  input  wire clkPkg::burstCnt_t burstCnt,
  output ebusPkg::ebusWord_t     diagDataOut
);

  logic [CYCLE_CNT_W-1:0] cycleCnt;  // Wraps at its own width

  ebusPkg::ebusWord_t statusWord;
  ebusPkg::ebusWord_t countWord;
  ebusPkg::ebusWord_t readWord;

  // One count per enabled EBOX cycle
  always_ff @(posedge masterClk) begin
    if (!rstN) begin
      cycleCnt <= '0;
    end else if (eboxClkEn) begin
      cycleCnt <= cycleCnt + 1'b1;
    end
  end

  // Status fields, upper bits read as zero
  always_comb begin
    statusWord = '0;
    statusWord[clkPkg::STAT_MR_RESET_BIT] = mrReset;
    statusWord[clkPkg::STAT_RUNNING_BIT]  = running;
    statusWord[clkPkg::STAT_STATE_LSB +: $bits(clkPkg::runState_t)] = state;
    statusWord[clkPkg::STAT_BURST_LSB +: clkPkg::BURST_CNT_W]       = burstCnt;
  end

  // Zero extend through the full counter type
  assign countWord = ebusPkg::ebusWord_t'(clkPkg::cycleCnt_t'(cycleCnt));

  assign readWord = (func == clkPkg::FUNC_READ_COUNT) ? countWord : statusWord;

  // Readback holds until the next read
  always_ff @(posedge masterClk) begin
    if (!rstN) begin
      diagDataOut <= '0;
    end else if (funcPulse && ebusPkg::isReadFunc(func)) begin
      diagDataOut <= readWord;
    end
  end

endmodule

`default_nettype wire

/* hw/clkCtl.sv */
`default_nettype none

module clkCtl #(
  parameter int CYCLE_CNT_W = 32  // 16 and 24 also fine
) (
  input  wire logic               masterClk,
  input  wire logic               rstN,
  input  wire ebusPkg::diagSel_t  diagSel,
  input  wire ebusPkg::diagFunc_t diagFunc,
  input  wire logic               diagStrobe,
  input  wire ebusPkg::ebusWord_t diagDataIn,
  output logic                    mrReset,
  output logic                    running,
  output logic                    eboxClkEn,
  output ebusPkg::ebusWord_t      diagDataOut
);

  logic              funcPulse;
  clkPkg::clkFunc_t  func;
  clkPkg::runState_t state;
  clkPkg::burstCnt_t burstCnt;

  // Bus strobe to one command pulse
  diagDecode decode (
    .masterClk  (masterClk),
    .rstN       (rstN),
    .diagSel    (diagSel),
    .diagFunc   (diagFunc),
    .diagStrobe (diagStrobe),
    .funcPulse  (funcPulse),
    .func       (func)
  );

  // Run control, burst length from low data byte
  clkExecute execute (
    .masterClk (masterClk),
    .rstN      (rstN),
    .funcPulse (funcPulse),
    .func      (func),
    .burstLen  (diagDataIn[clkPkg::BURST_CNT_W-1:0]),
    .mrReset   (mrReset),
    .running   (running),
    .eboxClkEn (eboxClkEn),
    .state     (state),
    .burstCnt  (burstCnt)
  );

  clkStatus #(
    .CYCLE_CNT_W (CYCLE_CNT_W)
  ) status (
    .masterClk   (masterClk),
    .rstN        (rstN),
    .funcPulse   (funcPulse),
    .func        (func),
    .eboxClkEn   (eboxClkEn),
    .mrReset     (mrReset),
    .running     (running),
    .state       (state),
    .burstCnt    (burstCnt),
    .diagDataOut (diagDataOut)
  );

endmodule

`default_nettype wire

/* verif/clkCtl_chk.sv */
`default_nettype none

module clkCtl_chk (
  input wire logic              masterClk,
  input wire logic              rstN,
  input wire ebusPkg::diagSel_t diagSel,
  input wire logic              diagStrobe,
  input wire logic              funcPulse,
  input wire logic              eboxClkEn,
  input wire clkPkg::runState_t state
);

  timeunit 1ns;
  timeprecision 1ps;

  // Command pulse is one cycle wide
  pulseOneCycle: assert property (@(posedge masterClk) disable iff (!rstN)
    funcPulse |=> !funcPulse) else $error("funcPulse high for two cycles");

  // Pulse two edges after a CLK strobe rise
  pulseAfterStrobe: assert property (@(posedge masterClk) disable iff (!rstN)
    funcPulse |-> $past(diagStrobe, 2) && !$past(diagStrobe, 3) &&
                  ($past(diagSel, 2) == ebusPkg::CLK_SEL))
    else $error("funcPulse without a CLK strobe rise");

  // Gate stays shut while stopped
  clkEnNotIdle: assert property (@(posedge masterClk) disable iff (!rstN)
    eboxClkEn |-> state != clkPkg::IDLE) else $error("eboxClkEn high in IDLE");

endmodule

// On the top so decode and execute nets are both in reach
bind clkCtl clkCtl_chk chk (
  .masterClk  (masterClk),
  .rstN       (rstN),
  .diagSel    (diagSel),
  .diagStrobe (diagStrobe),
  .funcPulse  (funcPulse),
  .eboxClkEn  (eboxClkEn),
  .state      (state)
);

`default_nettype wire

/* verif/clkCtlTb.sv */
`default_nettype none

module clkCtlTb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_REC       = 26;
  localparam int REC_FIELDS    = 6;    // Words per pattern line
  localparam int PULSE_TIMEOUT = 20;   // Strobe to pulse takes 2 or 3
  localparam int IDLE_TIMEOUT  = 600;  // Longest burst is 255

  // Check kinds, column 5 of the pattern file; anything else is an exact check
  localparam logic [3:0] MODE_DELTA   = 4'h1;  // Count growth since last count read
  localparam logic [3:0] MODE_CAPTURE = 4'h2;  // Count taken as new baseline
  localparam logic [3:0] MODE_HELD    = 4'h3;  // Exact check with the bus re-driven

  logic               masterClk;
  logic               rstN;
  ebusPkg::diagSel_t  diagSel;
  ebusPkg::diagFunc_t diagFunc;
  logic               diagStrobe;
  ebusPkg::ebusWord_t diagDataIn;
  logic               mrReset;
  logic               running;
  logic               eboxClkEn;
  ebusPkg::ebusWord_t diagDataOut;

  ebusPkg::ebusWord_t patMem [NUM_REC*REC_FIELDS];
  ebusPkg::ebusWord_t lastCount;  // Baseline for delta checks
  ebusPkg::ebusWord_t enCount;    // Enabled cycles seen on the eboxClkEn pin
  ebusPkg::ebusWord_t enBase;     // enCount at the last count read
  logic [31:0]        rngState;

  clkCtl #(
    .CYCLE_CNT_W (32)
  ) dut (
    .masterClk   (masterClk),
    .rstN        (rstN),
    .diagSel     (diagSel),
    .diagFunc    (diagFunc),
    .diagStrobe  (diagStrobe),
    .diagDataIn  (diagDataIn),
    .mrReset     (mrReset),
    .running     (running),
    .eboxClkEn   (eboxClkEn),
    .diagDataOut (diagDataOut)
  );

  always #20 masterClk = ~masterClk;  // 40 ns period

  // One tick per cycle the EBOX clock is gated on
  always @(negedge masterClk) begin
    if (rstN && eboxClkEn) begin
      enCount <= enCount + 1'b1;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic checkValue(input string name, input ebusPkg::ebusWord_t actual,
                            input ebusPkg::ebusWord_t expected);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: got 0x%09h, expected 0x%09h", name, actual, expected);
      $display("Result: FAILED");
      $fatal(1, "Value mismatch on %s", name);
    end
  endtask

  task automatic stopOnTimeout(input string what);
    $display("Timeout: %s", what);
    $display("Result: FAILED");
    $fatal(1, "Wait loop ran out");
  endtask

  // Random idle gap of 1 to 8 cycles
  task automatic idleRandomCycles();
    int gap;
    rngState = xorshift32(rngState);
    gap = int'(rngState[2:0]) + 1;
    repeat (gap) @(posedge masterClk);
  endtask

  // Returns on the negedge after the registers took the command
  task automatic waitForPulse();
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < PULSE_TIMEOUT) begin
      @(negedge masterClk);
      seen = dut.funcPulse;
      n++;
    end
    if (!seen) begin
      stopOnTimeout("no function pulse after the strobe");
    end else begin
      @(negedge masterClk);
    end
  endtask

  task automatic waitForIdle();
    int n;
    n = 0;
    @(negedge masterClk);
    while (running && n < IDLE_TIMEOUT) begin
      @(negedge masterClk);
      n++;
    end
    if (running) begin
      stopOnTimeout("burst did not return to idle");
    end
  endtask

  // Raise strobe, hold four cycles, drop it
  task automatic doClkFunction(input ebusPkg::diagSel_t sel, input ebusPkg::diagFunc_t fn,
                               input ebusPkg::ebusWord_t data);
    @(posedge masterClk);
    diagSel    <= sel;
    diagFunc   <= fn;
    diagDataIn <= data;  // Stays put until the next command
    diagStrobe <= 1'b1;
    if (sel == ebusPkg::CLK_SEL) begin
      waitForPulse();
    end else begin
      repeat (3) @(posedge masterClk);  // Nobody answers
    end
    @(posedge masterClk);
    diagStrobe <= 1'b0;
  endtask

  // Read, then swap the function under the same strobe
  task automatic heldReread(input ebusPkg::diagFunc_t fn);
    @(posedge masterClk);
    diagSel    <= ebusPkg::CLK_SEL;
    diagFunc   <= fn;
    diagStrobe <= 1'b1;
    waitForPulse();
    @(posedge masterClk);
    diagFunc <= (fn == ebusPkg::RD_FUNC_STATUS) ? ebusPkg::RD_FUNC_COUNT
                                                : ebusPkg::RD_FUNC_STATUS;
    repeat (4) @(posedge masterClk);  // Room for a wrong second pulse to land
    diagStrobe <= 1'b0;
  endtask

  task automatic runRecord(input int idx);
    ebusPkg::diagSel_t  sel;
    ebusPkg::diagFunc_t fn;
    ebusPkg::ebusWord_t data;
    ebusPkg::diagFunc_t rdFn;
    logic [3:0]         mode;
    ebusPkg::ebusWord_t expected;
    ebusPkg::ebusWord_t got;
    sel      = patMem[idx*REC_FIELDS + 0][3:0];
    fn       = patMem[idx*REC_FIELDS + 1][2:0];
    data     = patMem[idx*REC_FIELDS + 2];
    rdFn     = patMem[idx*REC_FIELDS + 3][2:0];
    mode     = patMem[idx*REC_FIELDS + 4][3:0];
    expected = patMem[idx*REC_FIELDS + 5];

    doClkFunction(sel, fn, data);
    if (sel == ebusPkg::CLK_SEL &&
        (fn == clkPkg::FUNC_BURST || fn == clkPkg::FUNC_SINGLE_STEP)) begin
      waitForIdle();
    end
    idleRandomCycles();

    if (mode == MODE_HELD) begin
      heldReread(rdFn);
    end else begin
      doClkFunction(ebusPkg::CLK_SEL, rdFn, data);
    end
    @(negedge masterClk);
    got = diagDataOut;
    case (mode)
      MODE_DELTA: begin
        checkValue($sformatf("diagDataOut count delta, rec %0d", idx),
                   got - lastCount, expected);
        checkValue($sformatf("eboxClkEn cycles, rec %0d", idx),
                   enCount - enBase, expected);
      end
      MODE_CAPTURE: ;  // Free-run length unknown
      default:      checkValue($sformatf("diagDataOut, rec %0d", idx), got, expected);
    endcase
    if (rdFn == ebusPkg::RD_FUNC_COUNT) begin
      lastCount = got;
      enBase    = enCount;
    end
    idleRandomCycles();
  endtask

  initial begin
    masterClk  = 1'b0;
    rstN       = 1'b0;
    diagSel    = '0;
    diagFunc   = '0;
    diagStrobe = 1'b0;
    diagDataIn = '0;
    lastCount  = '0;
    enCount    = '0;
    enBase     = '0;
    rngState   = 32'd2;  // Seed
    $readmemh("verif/clkPatterns.hex", patMem);

    repeat (10) @(posedge masterClk);
    rstN <= 1'b1;
    @(negedge masterClk);

    // Reset values before any read
    checkValue("diagDataOut", diagDataOut, '0);
    checkValue("mrReset", ebusPkg::ebusWord_t'(mrReset), ebusPkg::ebusWord_t'(1));
    checkValue("running", ebusPkg::ebusWord_t'(running), '0);
    checkValue("eboxClkEn", ebusPkg::ebusWord_t'(eboxClkEn), '0);

    for (int i = 0; i < NUM_REC; i++) begin
      runRecord(i);
    end

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/clkPatterns.hex */
// Columns: sel func data rdFunc mode expected
// sel/func go on the bus with data, then rdFunc is read back and checked
// mode 0 exact, 1 count growth since last count read, 2 count baseline only,
// mode 3 exact with the bus re-driven while the read strobe stays high
0 4 000000000 4 0 000000001
0 5 000000000 5 0 000000000
0 7 000000000 4 0 000000001
0 1 000000000 4 0 000000007
0 6 000000000 4 0 000000006
0 0 000000000 4 0 000000000
0 5 000000000 5 2 000000000
0 5 000000000 5 1 000000000
0 3 000000005 5 1 000000005
0 2 000000000 5 1 000000001
0 3 000000021 5 1 000000021
0 3 000000012 4 0 000000000
0 5 000000000 5 1 000000012
0 3 ABCDE0103 5 1 000000003
3 1 000000000 4 0 000000000
F 7 000000000 4 0 000000000
0 7 000000000 4 3 000000001
0 6 000000000 4 3 000000000
0 3 000000000 4 0 000000000
0 5 000000000 5 1 000000000
0 3 0000000FF 5 1 0000000FF
0 1 000000000 4 0 000000006
0 0 000000000 5 2 000000000
0 2 000000000 5 1 000000001
0 7 000000000 4 0 000000001
0 3 000000004 5 1 000000004

/* verilog.f */
hw/ebusPkg.sv
hw/clkPkg.sv
hw/diagDecode.sv
hw/clkExecute.sv
hw/clkStatus.sv
hw/clkCtl.sv
verif/clkCtl_chk.sv
verif/clkCtlTb.sv

/* run.sh */
#!/bin/sh
# Build and run the clkCtl testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module clkCtlTb \
  -Mdir obj_dir \
  -f verilog.f

# The log decides the result, not the exit status
./obj_dir/VclkCtlTb | tee sim.log

if grep -q "Result: PASSED" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
